//--- Bender.yml
package:
  name: ex

sources:
  - files:
      - rtl/ex_pkg.sv
      - rtl/ex_alu.sv
      - rtl/ex_bru.sv
      - rtl/ex_pipe.sv
      - rtl/ex.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/ex_tb.sv

//--- list.f
+incdir+testbench
rtl/ex_pkg.sv
rtl/ex_alu.sv
rtl/ex_bru.sv
rtl/ex_pipe.sv
rtl/ex.sv
testbench/ex_tb.sv

//--- rtl/ex.sv
// Execute stage top
// IW independent lanes, each with its own request and completion handshake
`timescale 1ns/100ps

module ex
(
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        flush,
   // From register read
   input  ex_pkg::ex_req_t             req [ex_pkg::IW],
   input  logic [ex_pkg::IW-1:0]       req_valid,
   output logic [ex_pkg::IW-1:0]       req_ready,
   // To writeback
   output ex_pkg::ex_rsp_t             rsp [ex_pkg::IW],
   output logic [ex_pkg::IW-1:0]       rsp_valid,
   input  logic [ex_pkg::IW-1:0]       rsp_ready
);
   import ex_pkg::*;

   genvar i;

   generate
      for (i = 0; i < IW; i = i + 1)
      begin : gen_lane
         ex_pipe u_pipe
         (
            .clk       (clk),
            .rst       (rst),
            .flush     (flush),           // Shared by all lanes
            .req       (req[i]),
            .req_valid (req_valid[i]),
            .req_ready (req_ready[i]),
            .rsp       (rsp[i]),
            .rsp_valid (rsp_valid[i]),
            .rsp_ready (rsp_ready[i])
         );
      end
   endgenerate

endmodule

//--- rtl/ex_alu.sv
// Integer ALU for one execute lane
// Pure combinational, flags codes outside the ALU table as illegal
`timescale 1ns/100ps

module ex_alu
(
   input  ex_pkg::opc_t  opc,
   input  ex_pkg::data_t operand1,
   input  ex_pkg::data_t operand2,
   output ex_pkg::data_t result,
   output logic          legal
);
   import ex_pkg::*;

   logic [SHAMT_W-1:0] shamt;          // Low bits of operand2
   data_t              add_res;
   data_t              sub_res;
   data_t              sll_res;
   data_t              srl_res;
   data_t              sra_res;
   logic               lt_signed;
   logic               lt_unsigned;

   assign shamt = operand2[SHAMT_W-1:0];

   // Adder and subtractor
   assign add_res = operand1 + operand2;
   assign sub_res = operand1 - operand2;

   // Barrel shifters
   assign sll_res = operand1 << shamt;
   assign srl_res = operand1 >> shamt;
   assign sra_res = data_t'($signed(operand1) >>> shamt); // Sign fill

   // Set-less-than compares
   assign lt_signed   = ($signed(operand1) < $signed(operand2));
   assign lt_unsigned = (operand1 < operand2);

   always_comb
   begin
      result = '0;
      legal  = 1'b1;                  // Cleared by default arm
      case (opc)
         OPC_ADD:  result = add_res;
         OPC_SUB:  result = sub_res;
         OPC_AND:  result = operand1 & operand2;
         OPC_OR:   result = operand1 | operand2;
         OPC_XOR:  result = operand1 ^ operand2;
         OPC_SLL:  result = sll_res;
         OPC_SRL:  result = srl_res;
         OPC_SRA:  result = sra_res;
         OPC_SLT:  result = data_t'(lt_signed);   // 0 or 1
         OPC_SLTU: result = data_t'(lt_unsigned); // 0 or 1
         default:  legal  = 1'b0;                 // Unused code
      endcase
   end

endmodule

//--- rtl/ex_bru.sv
// Branch resolver for one execute lane
// Computes direction, next pc, link address and misprediction against the BPU guess
`timescale 1ns/100ps

module ex_bru
(
   input  ex_pkg::opc_t  opc,
   input  ex_pkg::pc_t   pc,
   input  ex_pkg::data_t imm,
   input  ex_pkg::data_t operand1,
   input  ex_pkg::data_t operand2,
   input  logic          pred_taken,
   input  ex_pkg::pc_t   pred_tgt,
   output ex_pkg::pc_t   next_pc,
   output ex_pkg::data_t link,
   output logic          fls,
   output logic          legal
);
   import ex_pkg::*;

   pc_t  pc_inc;                       // Fall-through pc
   pc_t  target;                       // Taken target
   logic taken;

   assign pc_inc = pc + 1'b1;

   always_comb
   begin
      taken  = 1'b0;
      legal  = 1'b1;
      target = pc + imm[PC_W-1:0];     // pc-relative by default
      case (opc)
         OPC_BEQ: taken = (operand1 == operand2);
         OPC_BNE: taken = (operand1 != operand2);
         OPC_BLT: taken = ($signed(operand1) < $signed(operand2));
         OPC_BGE: taken = ($signed(operand1) >= $signed(operand2));
         OPC_JAL: taken = 1'b1;
         OPC_JALR:
         begin
            taken  = 1'b1;
            target = operand1[DW-1:DW-PC_W] + imm[PC_W-1:0]; // Register base, word part
         end
         default: legal = 1'b0;        // Not a branch code
      endcase
   end

   assign next_pc = taken ? target : pc_inc;

   // Return address as a byte address
   assign link = data_t'({pc_inc, 2'b00});

   // Wrong direction, or right direction with a stale target
   assign fls = (taken != pred_taken) | (taken & (target != pred_tgt));

endmodule

//--- rtl/ex_pipe.sv
// One execute lane
// Decodes the unit, runs ALU and BRU, and holds the completion in a one-entry output register
`timescale 1ns/100ps

module ex_pipe
(
   input  logic            clk,
   input  logic            rst,
   input  logic            flush,
   // From register read
   input  ex_pkg::ex_req_t req,
   input  logic            req_valid,
   output logic            req_ready,
   // To writeback
   output ex_pkg::ex_rsp_t rsp,
   output logic            rsp_valid,
   input  logic            rsp_ready
);
   import ex_pkg::*;

   data_t   alu_result;
   logic    alu_legal;
   pc_t     bru_next_pc;
   data_t   bru_link;
   logic    bru_fls;
   logic    bru_legal;
   logic    is_bru;                    // Unit select from opcode MSB
   logic    exc;
   pc_t     pc_inc;
   ex_rsp_t rsp_d;                     // Completion before the register
   ex_rsp_t rsp_q;                     // Held payload
   logic    prf_we_q;                  // Write enable kept with control state
   logic    push;

   ex_alu u_alu
   (
      .opc      (req.opc),
      .operand1 (req.operand1),
      .operand2 (req.operand2),
      .result   (alu_result),
      .legal    (alu_legal)
   );

   ex_bru u_bru
   (
      .opc        (req.opc),
      .pc         (req.pc),
      .imm        (req.imm),
      .operand1   (req.operand1),
      .operand2   (req.operand2),
      .pred_taken (req.pred_taken),
      .pred_tgt   (req.pred_tgt),
      .next_pc    (bru_next_pc),
      .link       (bru_link),
      .fls        (bru_fls),
      .legal      (bru_legal)
   );

   assign is_bru = req.opc[OPC_W-1];
   assign exc    = is_bru ? ~bru_legal : ~alu_legal; // Legal flag of the chosen unit
   assign pc_inc = req.pc + 1'b1;

   // Completion record
   always_comb
   begin
      rsp_d.rob_id   = req.rob_id;
      rsp_d.rob_bank = req.rob_bank;
      rsp_d.fls      = is_bru & bru_legal & bru_fls; // ALU never flushes
      rsp_d.exc      = exc;
      rsp_d.opera    = data_t'(is_bru ? bru_next_pc : pc_inc);
      rsp_d.prd      = req.prd;
      rsp_d.prf_we   = req.prd_we & ~exc;  // No write on exception
      rsp_d.wdata    = is_bru ? bru_link : alu_result;
   end

   // Accept when empty or draining, never during flush
   assign req_ready = (~rsp_valid | rsp_ready) & ~flush;
   assign push      = req_valid & req_ready;

   // Control state
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         rsp_valid <= 1'b0;
         prf_we_q  <= 1'b0;
      end
      else if (flush)
      begin
         rsp_valid <= 1'b0;            // Drop held completion
         prf_we_q  <= 1'b0;
      end
      else if (push)
      begin
         rsp_valid <= 1'b1;
         prf_we_q  <= rsp_d.prf_we;
      end
      else if (rsp_ready)
      begin
         rsp_valid <= 1'b0;            // Drained, nothing new
         prf_we_q  <= 1'b0;
      end
   end

   // Payload, loads on accept only
   always_ff @(posedge clk)
   begin
      if (push)
         rsp_q <= rsp_d;
   end

   always_comb
   begin
      rsp        = rsp_q;
      rsp.prf_we = prf_we_q;           // Low whenever the register is empty
   end

endmodule

//--- rtl/ex_pkg.sv
// Execute stage package
// Lane count, widths, opcode codes and the lane request/completion records
package ex_pkg;

   // Sizes
   localparam int IW             = 2;           // Lanes
   localparam int DW             = 32;          // Data width
   localparam int PC_W           = 30;          // Word-addressed pc
   localparam int PRF_AW         = 6;           // Physical register address
   localparam int P_ROB_DEPTH    = 4;           // ROB slot index
   localparam int P_COMMIT_WIDTH = 1;           // ROB bank index
   localparam int OPC_W          = 5;           // Opcode width, MSB picks unit
   localparam int SHAMT_W        = $clog2(DW);  // Shift amount bits

   typedef logic [DW-1:0]             data_t;
   typedef logic [PC_W-1:0]           pc_t;
   typedef logic [PRF_AW-1:0]         prf_addr_t;
   typedef logic [P_ROB_DEPTH-1:0]    rob_id_t;
   typedef logic [P_COMMIT_WIDTH-1:0] rob_bank_t;
   typedef logic [OPC_W-1:0]          opc_t;

   // ALU space, MSB clear
   localparam opc_t OPC_ADD  = 5'b0_0000;
   localparam opc_t OPC_SUB  = 5'b0_0001;
   localparam opc_t OPC_AND  = 5'b0_0010;
   localparam opc_t OPC_OR   = 5'b0_0011;
   localparam opc_t OPC_XOR  = 5'b0_0100;
   localparam opc_t OPC_SLL  = 5'b0_0101;
   localparam opc_t OPC_SRL  = 5'b0_0110;
   localparam opc_t OPC_SRA  = 5'b0_0111;
   localparam opc_t OPC_SLT  = 5'b0_1000;
   localparam opc_t OPC_SLTU = 5'b0_1001;

   // BRU space, MSB set
   localparam opc_t OPC_BEQ  = 5'b1_0000;
   localparam opc_t OPC_BNE  = 5'b1_0001;
   localparam opc_t OPC_BLT  = 5'b1_0010;
   localparam opc_t OPC_BGE  = 5'b1_0011;
   localparam opc_t OPC_JAL  = 5'b1_0100;
   localparam opc_t OPC_JALR = 5'b1_0101;

   // One issued instruction from register read
   typedef struct packed {
      opc_t      opc;
      logic      pred_taken;   // BPU direction guess
      pc_t       pred_tgt;     // BPU target guess
      pc_t       pc;
      data_t     imm;          // Word offset for branches
      data_t     operand1;
      data_t     operand2;
      prf_addr_t prd;
      logic      prd_we;
      rob_id_t   rob_id;
      rob_bank_t rob_bank;
   } ex_req_t;

   // One completion towards writeback
   typedef struct packed {
      rob_id_t   rob_id;
      rob_bank_t rob_bank;
      logic      fls;          // Misprediction, flush request
      logic      exc;          // Illegal opcode
      data_t     opera;        // Correct next pc, zero-extended
      prf_addr_t prd;
      logic      prf_we;
      data_t     wdata;
   } ex_rsp_t;

endpackage

//--- testbench/ex_vectors.svh
// Execute stage test vectors
// One row per request, with the completion worked out from the ALU and branch rules
`ifndef EX_VECTORS_SVH
`define EX_VECTORS_SVH

localparam int NUM_ROWS = 31;

typedef struct {
   int    lane;
   opc_t  opc;
   logic  pred_taken;
   pc_t   pred_tgt;
   pc_t   pc;
   data_t imm;
   data_t op1;
   data_t op2;
   logic  prd_we;
   logic  flush_after;                 // Flush pulse once accepted
   data_t exp_wdata;                   // Not compared on exception rows
   data_t exp_opera;
   logic  exp_fls;
   logic  exp_exc;
   logic  exp_prf_we;
} vec_t;

vec_t vectors [$];

task automatic add_row(input int lane, input opc_t opc, input logic pt, input pc_t ptgt,
                       input pc_t pc, input data_t imm, input data_t op1, input data_t op2,
                       input logic we, input logic fl, input data_t ew, input data_t eo,
                       input logic ef, input logic ee, input logic epw);
   vectors.push_back('{lane, opc, pt, ptgt, pc, imm, op1, op2, we, fl, ew, eo, ef, ee, epw});
endtask

// Columns: lane, opc, pred_taken, pred_tgt, pc, imm, operand1, operand2, prd_we, flush_after,
// then expected wdata, opera, fls, exc, prf_we
task automatic load_vectors();
   add_row(0, OPC_ADD,  1, 'h0, 'h100, 'h0, 'h5, 'h7, 1, 0, 'hC, 'h101, 0, 0, 1); // Stray guess
   add_row(1, OPC_SUB,  1, 'h0, 'h101, 'h0, 'h3, 'h5, 1, 0, 'hFFFF_FFFE, 'h102, 0, 0, 1);
   add_row(0, OPC_AND,  0, 'h0, 'h102, 'h0, 'hF0F0_F0F0, 'hFF00_FF00, 1, 0, 'hF000_F000,
           'h103, 0, 0, 1);
   add_row(1, OPC_OR,   0, 'h0, 'h103, 'h0, 'h1234_0000, 'h5678, 0, 0, 'h1234_5678,
           'h104, 0, 0, 0);                                   // No register write
   add_row(0, OPC_XOR,  0, 'h0, 'h104, 'h0, 'hAAAA_5555, 'hFFFF_FFFF, 1, 0, 'h5555_AAAA,
           'h105, 0, 0, 1);
   add_row(1, OPC_SLL,  0, 'h0, 'h105, 'h0, 'h1, 'h24, 1, 0, 'h10, 'h106, 0, 0, 1); // Shamt 4
   add_row(0, OPC_SRL,  0, 'h0, 'h106, 'h0, 'h8000_0000, 'h1F, 1, 0, 'h1, 'h107, 0, 0, 1);
   add_row(1, OPC_SRA,  0, 'h0, 'h107, 'h0, 'h8000_0000, 'h4, 1, 0, 'hF800_0000, 'h108, 0, 0, 1);
   add_row(0, OPC_SLT,  0, 'h0, 'h108, 'h0, 'hFFFF_FFFF, 'h1, 1, 0, 'h1, 'h109, 0, 0, 1);
   add_row(1, OPC_SLTU, 0, 'h0, 'h109, 'h0, 'hFFFF_FFFF, 'h1, 1, 0, 'h0, 'h10A, 0, 0, 1);
   add_row(0, OPC_SLT,  0, 'h0, 'h10A, 'h0, 'h5, 'hFFFF_FFFF, 1, 0, 'h0, 'h10B, 0, 0, 1);
   add_row(1, OPC_ADD,  0, 'h0, 'h10B, 'h0, 'hFFFF_FFFF, 'h1, 1, 1, 'h0, 'h10C, 0, 0, 1);
   add_row(0, OPC_SRA,  0, 'h0, 'h10C, 'h0, 'h7FFF_0000, 'h10, 1, 0, 'h7FFF, 'h10D, 0, 0, 1);
   add_row(1, OPC_SLL,  0, 'h0, 'h10D, 'h0, 'h8000_0001, 'h1, 1, 0, 'h2, 'h10E, 0, 0, 1);
   // Conditional branches, hits and misses
   add_row(0, OPC_BEQ,  1, 'h210, 'h200, 'h10, 'h7, 'h7, 0, 0, 'h804, 'h210, 0, 0, 0);
   add_row(1, OPC_BEQ,  1, 'h218, 'h210, 'h8, 'h7, 'h8, 0, 0, 'h844, 'h211, 1, 0, 0);
   add_row(0, OPC_BNE,  1, 'h2F0, 'h300, 'hFFFF_FFF0, 'h1, 'h2, 0, 0, 'hC04, 'h2F0, 0, 0, 0);
   add_row(1, OPC_BNE,  0, 'h0, 'h2F0, 'h4, 'h9, 'h9, 0, 0, 'hBC4, 'h2F1, 0, 0, 0);
   add_row(0, OPC_BLT,  0, 'h0, 'h400, 'h20, 'hFFFF_FFFE, 'h1, 0, 0, 'h1004, 'h420, 1, 0, 0);
   add_row(1, OPC_BLT,  0, 'h0, 'h420, 'h20, 'h1, 'hFFFF_FFFE, 0, 0, 'h1084, 'h421, 0, 0, 0);
   add_row(0, OPC_BGE,  1, 'h540, 'h500, 'h40, 'h5, 'h5, 0, 0, 'h1404, 'h540, 0, 0, 0);
   add_row(1, OPC_BGE,  1, 'h580, 'h540, 'h40, 'hFFFF_FFFF, 'h0, 0, 0, 'h1504, 'h541, 1, 0, 0);
   // Jumps with link writes
   add_row(0, OPC_JAL,  1, 'h6FF, 'h600, 'h100, 'h0, 'h0, 1, 0, 'h1804, 'h700, 1, 0, 1);
   add_row(1, OPC_JALR, 1, 'h800, 'h700, 'h4, 'h2000, 'h0, 1, 0, 'h1C04, 'h804, 1, 0, 1);
   add_row(0, OPC_JALR, 1, 'hC00, 'h804, 'h0, 'h3003, 'h0, 1, 0, 'h2014, 'hC00, 0, 0, 1);
   add_row(1, OPC_JAL,  0, 'h0, 'hC00, 'hFFFF_FFFF, 'h0, 'h0, 1, 0, 'h3004, 'hBFF, 1, 0, 1);
   // Illegal codes in both unit spaces
   add_row(0, 5'h0F,    0, 'h0, 'hD00, 'h0, 'h1, 'h1, 1, 0, 'h0, 'hD01, 0, 1, 0);
   add_row(1, 5'h1F,    0, 'h0, 'hD01, 'h0, 'h0, 'h0, 1, 0, 'h0, 'hD02, 0, 1, 0);
   // Flush victim, then normal traffic
   add_row(0, OPC_ADD,  0, 'h0, 'hE00, 'h0, 'h1, 'h1, 1, 1, 'h2, 'hE01, 0, 0, 1);
   add_row(1, OPC_XOR,  0, 'h0, 'hE01, 'h0, 'h0F0F_0F0F, 'hFFFF, 1, 0, 'h0F0F_F0F0,
           'hE02, 0, 0, 1);
   add_row(0, OPC_SUB,  0, 'h0, 'hE02, 'h0, 'h10, 'h10, 1, 0, 'h0, 'hE03, 0, 0, 1);
endtask

`endif

//--- testbench/ex_tb.sv
// Execute stage testbench
// Table-driven lanes with random back-pressure, flush and a completion scoreboard per lane
`timescale 1ns/100ps

module ex_tb;
   import ex_pkg::*;

   `include "ex_vectors.svh"

   localparam int CLK_PERIOD     = 40;
   localparam int RST_CYCLES     = 10;
   localparam int TIMEOUT_CYCLES = RST_CYCLES + NUM_ROWS * 20;

   logic          clk;
   logic          rst;
   logic          flush;
   ex_req_t       req [IW];
   logic [IW-1:0] req_valid;
   logic [IW-1:0] req_ready;
   ex_rsp_t       rsp [IW];
   logic [IW-1:0] rsp_valid;
   logic [IW-1:0] rsp_ready;
   logic [IW-1:0] rand_ready;          // Random part of rsp_ready
   logic [IW-1:0] accepted;            // Set by monitor on request transfer
   logic [IW-1:0] filled;              // Request transferred at last edge
   logic [IW-1:0] held_valid;          // Completion stalled at last edge
   ex_rsp_t       held_rsp [IW];
   ex_rsp_t       next_exp [IW];       // Expected completion of the row on the lane
   ex_rsp_t       exp_q [IW][$];       // Scoreboard, oldest first
   integer        seed = 32'ha7562b84;

   // Writeback never takes during flush
   assign rsp_ready = rand_ready & {IW{~flush}};

   ex ex_inst
   (
      .clk       (clk),
      .rst       (rst),
      .flush     (flush),
      .req       (req),
      .req_valid (req_valid),
      .req_ready (req_ready),
      .rsp       (rsp),
      .rsp_valid (rsp_valid),
      .rsp_ready (rsp_ready)
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   task automatic report_error(input string msg);
      $display("%s", msg);
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic check_equal(input string name, input logic [127:0] actual,
                              input logic [127:0] expected);
      if (actual !== expected)
         report_error($sformatf("Fail %s: actual 0x%0h, expected 0x%0h", name, actual, expected));
   endtask

   task automatic check_idle();
      for (int l = 0; l < IW; l++)
      begin
         check_equal($sformatf("rsp_valid[%0d]", l), rsp_valid[l], 1'b0);
         check_equal($sformatf("rsp[%0d].prf_we", l), rsp[l].prf_we, 1'b0);
      end
   endtask

   task automatic compare_rsp(input int l, input ex_rsp_t act, input ex_rsp_t want);
      check_equal($sformatf("rsp[%0d].rob_id", l), act.rob_id, want.rob_id);
      check_equal($sformatf("rsp[%0d].rob_bank", l), act.rob_bank, want.rob_bank);
      check_equal($sformatf("rsp[%0d].prd", l), act.prd, want.prd);
      check_equal($sformatf("rsp[%0d].fls", l), act.fls, want.fls);
      check_equal($sformatf("rsp[%0d].exc", l), act.exc, want.exc);
      check_equal($sformatf("rsp[%0d].opera", l), act.opera, want.opera);
      check_equal($sformatf("rsp[%0d].prf_we", l), act.prf_we, want.prf_we);
      if (!want.exc)
         check_equal($sformatf("rsp[%0d].wdata", l), act.wdata, want.wdata);
   endtask

   // Runs on each rising edge with the values from before the edge
   task automatic sample_lanes();
      ex_rsp_t want;
      for (int l = 0; l < IW; l++)
      begin
         if (filled[l])                // One-cycle latency
            check_equal($sformatf("rsp_valid[%0d] after accept", l), rsp_valid[l], 1'b1);
         if (held_valid[l])            // Stalled output must not move
         begin
            check_equal($sformatf("rsp_valid[%0d] held", l), rsp_valid[l], 1'b1);
            check_equal($sformatf("rsp[%0d] held", l), rsp[l], held_rsp[l]);
         end
         held_valid[l] = rsp_valid[l] & ~rsp_ready[l] & ~flush;
         held_rsp[l]   = rsp[l];
         if (!rsp_valid[l])
            check_equal($sformatf("rsp[%0d].prf_we idle", l), rsp[l].prf_we, 1'b0);
         if (rsp_valid[l] && rsp_ready[l])
         begin
            if (exp_q[l].size() == 0)
               report_error($sformatf("Lane %0d delivered a completion that was never issued", l));
            else
            begin
               want = exp_q[l].pop_front();
               compare_rsp(l, rsp[l], want);
            end
         end
         if (flush)
            check_equal($sformatf("req_ready[%0d] in flush", l), req_ready[l], 1'b0);
         filled[l] = req_valid[l] & req_ready[l];
         if (req_valid[l] && req_ready[l])
         begin
            exp_q[l].push_back(next_exp[l]);
            accepted[l] = 1'b1;
         end
         if (flush)
            exp_q[l].delete();         // Held completions are dropped
      end
   endtask

   always @(posedge clk)
   begin
      if (!rst)
         sample_lanes();
   end

   task automatic drive_row(input int idx);
      vec_t    v;
      ex_rsp_t want;
      int      l;
      v                 = vectors[idx];
      l                 = v.lane;
      req[l].opc        = v.opc;
      req[l].pred_taken = v.pred_taken;
      req[l].pred_tgt   = v.pred_tgt;
      req[l].pc         = v.pc;
      req[l].imm        = v.imm;
      req[l].operand1   = v.op1;
      req[l].operand2   = v.op2;
      req[l].prd        = prf_addr_t'(idx);            // Tags follow the row number
      req[l].prd_we     = v.prd_we;
      req[l].rob_id     = rob_id_t'(idx);
      req[l].rob_bank   = rob_bank_t'(idx >> P_ROB_DEPTH);
      want.rob_id       = rob_id_t'(idx);
      want.rob_bank     = rob_bank_t'(idx >> P_ROB_DEPTH);
      want.prd          = prf_addr_t'(idx);
      want.fls          = v.exp_fls;
      want.exc          = v.exp_exc;
      want.opera        = v.exp_opera;
      want.prf_we       = v.exp_prf_we;
      want.wdata        = v.exp_wdata;
      next_exp[l]       = want;
      accepted[l]       = 1'b0;
      req_valid[l]      = 1'b1;
      @(negedge clk);
      while (!accepted[l])
         @(negedge clk);
      req_valid[l] = 1'b0;
   endtask

   task automatic pulse_flush();
      flush = 1'b1;
      @(negedge clk);
      flush = 1'b0;
   endtask

   function automatic int pending_count();
      int n;
      n = 0;
      for (int l = 0; l < IW; l++)
         n += exp_q[l].size();
      return n;
   endfunction

   // Back-pressure, about one stall cycle in four
   initial
   begin
      logic [31:0] r;
      forever
      begin
         @(negedge clk);
         r = $random(seed);
         for (int l = 0; l < IW; l++)
            rand_ready[l] = (r[2*l +: 2] != 2'b00);
      end
   end

   initial
   begin
      #(TIMEOUT_CYCLES * CLK_PERIOD);
      report_error($sformatf("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES));
   end

   initial
   begin
      rst        = 1'b1;
      flush      = 1'b0;
      req_valid  = '0;
      rand_ready = '0;
      accepted   = '0;
      filled     = '0;
      held_valid = '0;
      for (int l = 0; l < IW; l++)
         req[l] = '0;
      load_vectors();
      if (vectors.size() != NUM_ROWS)
         report_error("Vector table does not hold the expected number of rows");
      repeat (RST_CYCLES)
      begin
         @(negedge clk);
         check_idle();                 // Outputs quiet while in reset
      end
      rst = 1'b0;
      @(negedge clk);
      check_idle();
      for (int i = 0; i < vectors.size(); i++)
      begin
         drive_row(i);
         if (vectors[i].flush_after)
            pulse_flush();
      end
      while (pending_count() != 0)
         @(negedge clk);
      repeat (4) @(negedge clk);       // Catch stray completions
      $display("Test passed");
      $finish;
   end

endmodule
